// ==== hdl/axi4_reg_if.sv ====
// AXI4 register bus
`timescale 1ns/100ps
`include "osc_cfg.svh"

interface axi4_reg_if (
  input logic cif,
  input logic rst_n
);

  import osc_pkg::*;

  // Write address channel
  logic [`OSC_AXI_ADDR_WIDTH-1:0] awaddr;
  logic                           awvalid;
  logic                           awready;

  // Write data channel
  logic [`OSC_AXI_DATA_WIDTH-1:0] wdata;
  logic                           wlast;
  logic                           wvalid;
  logic                           wready;

  // Write response channel
  axi_resp_t                      bresp;
  logic                           bvalid;
  logic                           bready;

  // Read address channel, burst of arlen+1 beats
  logic [`OSC_AXI_ADDR_WIDTH-1:0] araddr;
  logic [7:0]                     arlen;
  logic                           arvalid;
  logic                           arready;

  // Read data channel
  logic [`OSC_AXI_DATA_WIDTH-1:0] rdata;
  axi_resp_t                      rresp;
  logic                           rlast;
  logic                           rvalid;
  logic                           rready;

  // Host side
  modport master (
    output awaddr, awvalid, wdata, wlast, wvalid, bready, araddr, arlen, arvalid, rready,
    input  awready, wready, bresp, bvalid, arready, rdata, rresp, rlast, rvalid
  );

  // Register block side
  modport slave (
    input  awaddr, awvalid, wdata, wlast, wvalid, bready, araddr, arlen, arvalid, rready,
    output awready, wready, bresp, bvalid, arready, rdata, rresp, rlast, rvalid
  );

  // Master keeps an address request up and stable until it is taken
  a_aw_hold: assert property (@(posedge cif) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable(awaddr));
  a_ar_hold: assert property (@(posedge cif) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen));

endinterface

// ==== hdl/osc_axi_slave.sv ====
// Oscillator register block
`timescale 1ns/100ps
`include "osc_cfg.svh"

module osc_axi_slave (
  input  logic                       cif,
  input  logic                       rst_n,
  axi4_reg_if.slave                  bus,
  output osc_pkg::osc_waveform_t     waveform_select,
  output logic [`OSC_N_BITS-1:0]     frequency,
  output logic [`OSC_N_BITS-1:0]     duty_cycle
);

  import osc_pkg::*;

  // Address step between beats, one data word
  localparam logic [`OSC_AXI_ADDR_WIDTH-1:0] ADDR_STEP = `OSC_AXI_DATA_WIDTH / 8;

  // --------------------
  // Declarations
  // --------------------

  typedef enum logic [1:0] {
    WR_IDLE_E,
    WR_DATA_E,
    WR_RESP_E
  } wr_state_t;

  typedef enum logic {
    RD_IDLE_E,
    RD_DATA_E
  } rd_state_t;

  wr_state_t                      wr_state;
  logic [`OSC_AXI_ADDR_WIDTH-1:0] wr_addr;

  rd_state_t                      rd_state;
  logic [`OSC_AXI_ADDR_WIDTH-1:0] rd_addr;
  // Beats left after the current one
  logic [7:0]                     rd_count;

  // --------------------
  // Write bursts
  // --------------------

  always_ff @(posedge cif or negedge rst_n) begin
    if (!rst_n) begin
      wr_state        <= WR_IDLE_E;
      wr_addr         <= '0;
      bus.awready     <= 1'b0;
      bus.wready      <= 1'b0;
      bus.bvalid      <= 1'b0;
      bus.bresp       <= AXI_RESP_OKAY;
      waveform_select <= OSC_SQUARE_E;
      frequency       <= `OSC_FREQUENCY_RST;
      duty_cycle      <= `OSC_DUTY_CYCLE_RST;
    end else begin
      case (wr_state)
        WR_IDLE_E: begin
          // Ready one cycle after reset and whenever idle
          bus.awready <= 1'b1;
          if (bus.awvalid && bus.awready) begin
            wr_state    <= WR_DATA_E;
            wr_addr     <= bus.awaddr;
            bus.awready <= 1'b0;
            bus.wready  <= 1'b1;
            // Fresh burst starts clean
            bus.bresp   <= AXI_RESP_OKAY;
          end
        end

        WR_DATA_E: begin
          if (bus.wvalid && bus.wready) begin
            wr_addr <= wr_addr + ADDR_STEP;
            case (wr_addr)
              `OSC_WAVEFORM_SELECT_ADDR: begin
                waveform_select <= osc_waveform_t'(bus.wdata[1:0]);
              end
              `OSC_FREQUENCY_ADDR: begin
                frequency <= bus.wdata[`OSC_N_BITS-1:0];
              end
              `OSC_DUTY_CYCLE_ADDR: begin
                duty_cycle <= bus.wdata[`OSC_N_BITS-1:0];
              end
              default: begin
                // Sticky for the rest of the burst
                bus.bresp <= AXI_RESP_SLVERR;
              end
            endcase
            // Last beat closes the data phase
            if (bus.wlast) begin
              wr_state   <= WR_RESP_E;
              bus.wready <= 1'b0;
              bus.bvalid <= 1'b1;
            end
          end
        end

        WR_RESP_E: begin
          // Wait here as long as bready stays low
          if (bus.bvalid && bus.bready) begin
            wr_state    <= WR_IDLE_E;
            bus.bvalid  <= 1'b0;
            bus.awready <= 1'b1;
          end
        end

        default: begin
          wr_state <= WR_IDLE_E;
        end
      endcase
    end
  end

  // --------------------
  // Read bursts
  // --------------------

  // Final beat once the count runs out
  assign bus.rlast = (rd_count == '0);

  always_ff @(posedge cif or negedge rst_n) begin
    if (!rst_n) begin
      rd_state    <= RD_IDLE_E;
      rd_addr     <= '0;
      rd_count    <= '0;
      bus.arready <= 1'b0;
      bus.rvalid  <= 1'b0;
    end else begin
      case (rd_state)
        RD_IDLE_E: begin
          bus.arready <= 1'b1;
          if (bus.arvalid && bus.arready) begin
            rd_state    <= RD_DATA_E;
            rd_addr     <= bus.araddr;
            rd_count    <= bus.arlen;
            bus.arready <= 1'b0;
            bus.rvalid  <= 1'b1;
          end
        end

        RD_DATA_E: begin
          // Position moves only on an accepted beat
          if (bus.rvalid && bus.rready) begin
            if (bus.rlast) begin
              rd_state    <= RD_IDLE_E;
              bus.rvalid  <= 1'b0;
              bus.arready <= 1'b1;
            end else begin
              rd_addr  <= rd_addr + ADDR_STEP;
              rd_count <= rd_count - 8'd1;
            end
          end
        end

        default: begin
          rd_state <= RD_IDLE_E;
        end
      endcase
    end
  end

  // Read data follows the current address
  always_comb begin
    bus.rdata = '0;
    bus.rresp = AXI_RESP_OKAY;
    case (rd_addr)
      `OSC_WAVEFORM_SELECT_ADDR: begin
        bus.rdata[1:0] = waveform_select;
      end
      `OSC_FREQUENCY_ADDR: begin
        bus.rdata[`OSC_N_BITS-1:0] = frequency;
      end
      `OSC_DUTY_CYCLE_ADDR: begin
        bus.rdata[`OSC_N_BITS-1:0] = duty_cycle;
      end
      default: begin
        bus.rresp = AXI_RESP_SLVERR;
      end
    endcase
  end

  // --------------------
  // Assertions
  // --------------------

  // Response held until the host takes it
  a_bvalid_hold: assert property (@(posedge cif) disable iff (!rst_n)
    bus.bvalid && !bus.bready |=> bus.bvalid);

  // Read data never overlaps a new address accept
  a_rvalid_rise: assert property (@(posedge cif) disable iff (!rst_n)
    $rose(bus.rvalid) |-> !bus.arready);

  // Data phase and response phase are exclusive
  a_w_b_excl: assert property (@(posedge cif) disable iff (!rst_n)
    !(bus.wready && bus.bvalid));

endmodule

// ==== hdl/osc_cfg.svh ====
// Oscillator configuration
`ifndef OSC_CFG_SVH
`define OSC_CFG_SVH

// --------------------
// Register bus
// --------------------

// Byte address width of the register port
`define OSC_AXI_ADDR_WIDTH 16
// Data word width, one register per word
`define OSC_AXI_DATA_WIDTH 32

// --------------------
// Oscillator widths
// --------------------

// Phase accumulator, frequency and duty cycle
`define OSC_N_BITS 24
// Signed sample width
`define OSC_AUDIO_WIDTH 24

// --------------------
// Register map
// --------------------

`define OSC_WAVEFORM_SELECT_ADDR 16'h0000
`define OSC_FREQUENCY_ADDR 16'h0004
`define OSC_DUTY_CYCLE_ADDR 16'h0008

// Reset values, the duty cycle at half the phase range
`define OSC_FREQUENCY_RST 24'h010000
`define OSC_DUTY_CYCLE_RST 24'h800000

`endif

// ==== hdl/osc_core.sv ====
// Oscillator core
`timescale 1ns/100ps
`include "osc_cfg.svh"

module osc_core (
  input  logic                               cif,
  input  logic                               rst_n,
  input  logic                               sample_tick,
  input  osc_pkg::osc_waveform_t             waveform_select,
  input  logic [`OSC_N_BITS-1:0]             frequency,
  input  logic [`OSC_N_BITS-1:0]             duty_cycle,
  output logic signed [`OSC_AUDIO_WIDTH-1:0] audio_out,
  output logic                               audio_valid
);

  import osc_pkg::*;

  localparam int A = `OSC_AUDIO_WIDTH;

  // Full scale sample levels
  localparam logic [A-1:0] MAX_POS = {1'b0, {(A-1){1'b1}}};
  localparam logic [A-1:0] MAX_NEG = {1'b1, {(A-1){1'b0}}};

  // --------------------
  // Declarations
  // --------------------

  logic [`OSC_N_BITS-1:0] phase;

  // Upper phase bits at sample width
  logic [A-1:0]           phase_top;
  // Triangle folding steps
  logic [A-1:0]           tri_fold;
  logic [A-1:0]           tri_twice;
  logic [A-1:0]           shaped;

  // --------------------
  // Waveform shaping
  // --------------------

  assign phase_top = phase[`OSC_N_BITS-1 -: A];

  // Second half of the cycle mirrors the first
  assign tri_fold  = phase_top[A-1] ? ~phase_top : phase_top;
  assign tri_twice = {tri_fold[A-2:0], 1'b0};

  always_comb begin
    case (waveform_select)
      OSC_SQUARE_E: begin
        // High part set by the duty cycle
        shaped = (phase < duty_cycle) ? MAX_POS : MAX_NEG;
      end
      OSC_SAW_E: begin
        // Offset binary to two's complement
        shaped = {~phase_top[A-1], phase_top[A-2:0]};
      end
      OSC_TRIANGLE_E: begin
        shaped = {~tri_twice[A-1], tri_twice[A-2:0]};
      end
      default: begin
        shaped = '0;
      end
    endcase
  end

  // --------------------
  // Accumulator and output
  // --------------------

  always_ff @(posedge cif or negedge rst_n) begin
    if (!rst_n) begin
      phase       <= '0;
      audio_out   <= '0;
      audio_valid <= 1'b0;
    end else begin
      // Strobe for the cycle after each tick
      audio_valid <= sample_tick;
      if (sample_tick) begin
        // Wraps modulo 2^N
        phase     <= phase + frequency;
        audio_out <= signed'(shaped);
      end
    end
  end

  // A sample only follows a tick
  a_valid_after_tick: assert property (@(posedge cif) disable iff (!rst_n)
    audio_valid |-> $past(sample_tick));

endmodule

// ==== hdl/osc_pkg.sv ====
// Oscillator types
package osc_pkg;

  // --------------------
  // Waveform select
  // --------------------

  // Code held in the waveform select register
  typedef enum logic [1:0] {
    OSC_SQUARE_E   = 2'd0,
    OSC_SAW_E      = 2'd1,
    OSC_TRIANGLE_E = 2'd2,
    OSC_SILENT_E   = 2'd3
  } osc_waveform_t;

  // --------------------
  // AXI response
  // --------------------

  // Two bit response code on b and r
  typedef logic [1:0] axi_resp_t;

  // Normal access
  localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

  // Unknown register address
  localparam axi_resp_t AXI_RESP_SLVERR = 2'b10;

endpackage

// ==== hdl/osc_top.sv ====
// Oscillator top level
`timescale 1ns/100ps
`include "osc_cfg.svh"

module osc_top (
  input  logic                               cif,
  input  logic                               rst_n,
  // Write address
  input  logic [`OSC_AXI_ADDR_WIDTH-1:0]     awaddr,
  input  logic                               awvalid,
  output logic                               awready,
  // Write data
  input  logic [`OSC_AXI_DATA_WIDTH-1:0]     wdata,
  input  logic                               wlast,
  input  logic                               wvalid,
  output logic                               wready,
  // Write response
  output osc_pkg::axi_resp_t                 bresp,
  output logic                               bvalid,
  input  logic                               bready,
  // Read address
  input  logic [`OSC_AXI_ADDR_WIDTH-1:0]     araddr,
  input  logic [7:0]                         arlen,
  input  logic                               arvalid,
  output logic                               arready,
  // Read data
  output logic [`OSC_AXI_DATA_WIDTH-1:0]     rdata,
  output osc_pkg::axi_resp_t                 rresp,
  output logic                               rlast,
  output logic                               rvalid,
  input  logic                               rready,
  // Audio
  input  logic                               sample_tick,
  output logic signed [`OSC_AUDIO_WIDTH-1:0] audio_out,
  output logic                               audio_valid
);

  import osc_pkg::*;

  // Control registers to the core
  osc_waveform_t          waveform_select;
  logic [`OSC_N_BITS-1:0] frequency;
  logic [`OSC_N_BITS-1:0] duty_cycle;

  axi4_reg_if reg_bus (.cif(cif), .rst_n(rst_n));

  // --------------------
  // Host side of the bus
  // --------------------

  assign reg_bus.awaddr  = awaddr;
  assign reg_bus.awvalid = awvalid;
  assign reg_bus.wdata   = wdata;
  assign reg_bus.wlast   = wlast;
  assign reg_bus.wvalid  = wvalid;
  assign reg_bus.bready  = bready;
  assign reg_bus.araddr  = araddr;
  assign reg_bus.arlen   = arlen;
  assign reg_bus.arvalid = arvalid;
  assign reg_bus.rready  = rready;

  assign awready = reg_bus.awready;
  assign wready  = reg_bus.wready;
  assign bresp   = reg_bus.bresp;
  assign bvalid  = reg_bus.bvalid;
  assign arready = reg_bus.arready;
  assign rdata   = reg_bus.rdata;
  assign rresp   = reg_bus.rresp;
  assign rlast   = reg_bus.rlast;
  assign rvalid  = reg_bus.rvalid;

  osc_axi_slave i_osc_axi_slave (
    .cif             (cif),
    .rst_n           (rst_n),
    .bus             (reg_bus.slave),
    .waveform_select (waveform_select),
    .frequency       (frequency),
    .duty_cycle      (duty_cycle)
  );

  osc_core i_osc_core (
    .cif             (cif),
    .rst_n           (rst_n),
    .sample_tick     (sample_tick),
    .waveform_select (waveform_select),
    .frequency       (frequency),
    .duty_cycle      (duty_cycle),
    .audio_out       (audio_out),
    .audio_valid     (audio_valid)
  );

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/osc_pkg.sv
hdl/axi4_reg_if.sv
hdl/osc_axi_slave.sv
hdl/osc_core.sv
hdl/osc_top.sv
verification/osc_tb.sv

// ==== verification/osc_tb.sv ====
// Oscillator testbench
`timescale 1ns/100ps
`include "osc_cfg.svh"

module osc_tb;

  import osc_pkg::*;

  // Longest run is under 300 cycles, with a wide margin
  localparam int TIMEOUT_CYCLES = 4000;

  localparam int N = `OSC_N_BITS;
  localparam logic [N-1:0] SIGN_BIT = 1 << (N - 1);
  localparam logic [N-1:0] MAX_POS  = SIGN_BIT - 1;

  // --------------------
  // DUT signals
  // --------------------

  logic                               cif;
  logic                               rst_n;
  logic [`OSC_AXI_ADDR_WIDTH-1:0]     awaddr;
  logic                               awvalid;
  logic                               awready;
  logic [`OSC_AXI_DATA_WIDTH-1:0]     wdata;
  logic                               wlast;
  logic                               wvalid;
  logic                               wready;
  axi_resp_t                          bresp;
  logic                               bvalid;
  logic                               bready;
  logic [`OSC_AXI_ADDR_WIDTH-1:0]     araddr;
  logic [7:0]                         arlen;
  logic                               arvalid;
  logic                               arready;
  logic [`OSC_AXI_DATA_WIDTH-1:0]     rdata;
  axi_resp_t                          rresp;
  logic                               rlast;
  logic                               rvalid;
  logic                               rready;
  logic                               sample_tick;
  logic signed [`OSC_AUDIO_WIDTH-1:0] audio_out;
  logic                               audio_valid;

  // Reference model state and expected values
  logic [1:0]                     model_wave;
  logic [N-1:0]                   model_freq;
  logic [N-1:0]                   model_duty;
  logic [N-1:0]                   model_phase;
  logic [N-1:0]                   exp_audio;
  logic [`OSC_AXI_DATA_WIDTH-1:0] exp_rdata;
  axi_resp_t                      exp_rresp;
  logic                           exp_rlast;
  axi_resp_t                      exp_bresp;
  logic [`OSC_AXI_DATA_WIDTH-1:0] burst_data [0:2];
  integer                         seed;
  int                             cycle_count;

  osc_top i_osc_top (.*);

  // --------------------
  // Failure reporting
  // --------------------

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    stop_on_failure($sformatf("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h",
                              $time, name, expected, actual));
  endtask

  // --------------------
  // Reference model
  // --------------------

  // Register write, returns 1 for an unknown address
  function automatic logic store_reg(input logic [15:0] addr, input logic [31:0] data);
    case (addr)
      `OSC_WAVEFORM_SELECT_ADDR: model_wave = data[1:0];
      `OSC_FREQUENCY_ADDR:       model_freq = data[N-1:0];
      `OSC_DUTY_CYCLE_ADDR:      model_duty = data[N-1:0];
      default:                   return 1'b1;
    endcase
    return 1'b0;
  endfunction

  function automatic void predict_read(input logic [15:0] addr, output logic [31:0] data,
                                       output axi_resp_t resp);
    data = '0;
    resp = AXI_RESP_OKAY;
    case (addr)
      `OSC_WAVEFORM_SELECT_ADDR: data[1:0]   = model_wave;
      `OSC_FREQUENCY_ADDR:       data[N-1:0] = model_freq;
      `OSC_DUTY_CYCLE_ADDR:      data[N-1:0] = model_duty;
      default:                   resp        = AXI_RESP_SLVERR;
    endcase
  endfunction

  // Sample for phase p under the current model registers
  function automatic logic [N-1:0] shape_sample(input logic [N-1:0] p);
    logic [N-1:0] folded;
    folded = p[N-1] ? ~p : p;
    case (model_wave)
      OSC_SQUARE_E:   return (p < model_duty) ? MAX_POS : SIGN_BIT;
      OSC_SAW_E:      return p ^ SIGN_BIT;
      OSC_TRIANGLE_E: return (folded << 1) ^ SIGN_BIT;
      default:        return '0;
    endcase
  endfunction

  // Old phase shapes the sample, then the phase steps
  always @(posedge cif) begin
    if (rst_n && sample_tick) begin
      exp_audio   <= shape_sample(model_phase);
      model_phase <= model_phase + model_freq;
    end
  end

  // --------------------
  // Bus tasks
  // --------------------

  // Ready is sampled on the falling edge, so the handshake lands on the next rising edge
  task automatic write_burst(input logic [15:0] addr, input int beats);
    logic [15:0] a;
    logic        bad;
    int          stall;
    a   = addr;
    bad = 1'b0;
    @(negedge cif);
    awaddr  = addr;
    awvalid = 1'b1;
    while (!awready) @(negedge cif);
    @(negedge cif);
    awvalid = 1'b0;
    for (int i = 0; i < beats; i++) begin
      wdata  = burst_data[i];
      wlast  = (i == beats - 1);
      wvalid = 1'b1;
      while (!wready) @(negedge cif);
      @(negedge cif);
      bad = bad | store_reg(a, burst_data[i]);
      a   = a + 16'd4;
    end
    wvalid    = 1'b0;
    wlast     = 1'b0;
    exp_bresp = bad ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
    // Hold off the response for a few cycles
    stall = 1 + ($unsigned($random(seed)) % 5);
    while (!bvalid) @(negedge cif);
    repeat (stall) @(negedge cif);
    bready = 1'b1;
    @(negedge cif);
    bready = 1'b0;
  endtask

  task automatic read_burst(input logic [15:0] addr, input logic [7:0] len, input bit stalls);
    logic [15:0] a;
    logic        taken;
    a = addr;
    @(negedge cif);
    araddr  = addr;
    arlen   = len;
    arvalid = 1'b1;
    while (!arready) @(negedge cif);
    @(negedge cif);
    arvalid = 1'b0;
    for (int beat = 0; beat <= len; beat++) begin
      predict_read(a, exp_rdata, exp_rresp);
      exp_rlast = (beat == len);
      taken     = 1'b0;
      while (!taken) begin
        rready = stalls ? (($random(seed) & 1) != 0) : 1'b1;
        taken  = rvalid && rready;
        @(negedge cif);
      end
      a = a + 16'd4;
    end
    rready = 1'b0;
  endtask

  // --------------------
  // Checks
  // --------------------

  a_rdata: assert property (@(posedge cif) disable iff (!rst_n)
    rvalid && rready |-> rdata == exp_rdata)
    else report_mismatch("rdata", $sampled(exp_rdata), $sampled(rdata));
  a_rresp: assert property (@(posedge cif) disable iff (!rst_n)
    rvalid && rready |-> rresp == exp_rresp)
    else report_mismatch("rresp", $sampled(exp_rresp), $sampled(rresp));
  a_rlast: assert property (@(posedge cif) disable iff (!rst_n)
    rvalid && rready |-> rlast == exp_rlast)
    else report_mismatch("rlast", $sampled(exp_rlast), $sampled(rlast));
  a_r_hold: assert property (@(posedge cif) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else stop_on_failure("Read beat changed while rready was low");
  a_ar_to_r: assert property (@(posedge cif) disable iff (!rst_n)
    arvalid && arready |=> rvalid && !arready)
    else stop_on_failure("Read data did not start one cycle after the address");
  a_aw_to_w: assert property (@(posedge cif) disable iff (!rst_n)
    awvalid && awready |=> wready && !awready)
    else stop_on_failure("Write data phase did not start after the address");
  a_wlast: assert property (@(posedge cif) disable iff (!rst_n)
    wvalid && wready && wlast |=> !wready && bvalid)
    else stop_on_failure("Last write beat did not lead to a response");
  a_bresp: assert property (@(posedge cif) disable iff (!rst_n)
    bvalid && bready |-> bresp == exp_bresp)
    else report_mismatch("bresp", $sampled(exp_bresp), $sampled(bresp));
  a_b_hold: assert property (@(posedge cif) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && !awready)
    else stop_on_failure("Write response dropped or awready rose before bready");
  a_b_done: assert property (@(posedge cif) disable iff (!rst_n)
    bvalid && bready |=> !bvalid && awready)
    else stop_on_failure("Slave did not return to idle after the write response");
  a_tick_valid: assert property (@(posedge cif) disable iff (!rst_n)
    sample_tick |=> audio_valid)
    else stop_on_failure("No audio_valid in the cycle after a sample tick");
  a_valid_tick: assert property (@(posedge cif) disable iff (!rst_n)
    !sample_tick |=> !audio_valid)
    else stop_on_failure("audio_valid without a sample tick before it");
  a_audio: assert property (@(posedge cif) disable iff (!rst_n)
    audio_valid |-> audio_out == exp_audio)
    else report_mismatch("audio_out", $sampled(exp_audio), $sampled(audio_out));

  // --------------------
  // Clock, timeout, stimulus
  // --------------------

  initial begin
    cif = 1'b0;
    forever #2 cif = ~cif;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge cif);
      cycle_count++;
    end
    stop_on_failure("Timeout, the run did not finish within the cycle limit");
  end

  initial begin
    seed        = 32'h182;
    rst_n       = 1'b0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wlast       = 1'b0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arlen       = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    sample_tick = 1'b0;
    model_wave  = OSC_SQUARE_E;
    model_freq  = `OSC_FREQUENCY_RST;
    model_duty  = `OSC_DUTY_CYCLE_RST;
    model_phase = '0;
    exp_audio   = '0;
    exp_rdata   = '0;
    exp_rresp   = AXI_RESP_OKAY;
    exp_rlast   = 1'b0;
    exp_bresp   = AXI_RESP_OKAY;
    // Four rising edges in reset, release on the falling edge after them
    repeat (4) @(posedge cif);
    @(negedge cif);
    rst_n = 1'b1;

    // Reset values
    read_burst(16'h0000, 8'd2, 1'b0);

    // Full burst write and read back under stalls
    for (int i = 0; i < 3; i++) burst_data[i] = $random(seed);
    write_burst(16'h0000, 3);
    read_burst(16'h0000, 8'd2, 1'b1);

    // Burst running past the register map
    burst_data[0] = $random(seed);
    burst_data[1] = $random(seed);
    write_burst(16'h0008, 2);
    read_burst(16'h0008, 8'd2, 1'b1);

    // Every waveform with random frequency and duty
    for (int code = 0; code < 4; code++) begin
      burst_data[0] = code;
      burst_data[1] = $random(seed);
      burst_data[2] = $random(seed);
      write_burst(16'h0000, 3);
      repeat (40) begin
        sample_tick = ($random(seed) & 1) != 0;
        @(negedge cif);
      end
      sample_tick = 1'b0;
      repeat (2) @(negedge cif);
    end

    repeat (4) @(negedge cif);
    $display("Everything OK");
    $finish;
  end

endmodule
